//--- common/cpu_cfg.svh
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Width of every register, ALU operand and memory word
`define CPU_DATA_W 16

// Register IDs are one nibble of the instruction word
`define CPU_REG_ID_W 4

// Architectural registers, entry 0 reads as zero
`define CPU_NUM_REGS 16

// Data memory words, addressed by the low byte of base plus offset
`define CPU_MEM_DEPTH 256

`endif

//--- common/cpuPkg.sv
`include "cpu_cfg.svh"

package cpuPkg;

  // Top nibble of each instruction word
  typedef enum logic [3:0] {
    OP_ADD  = 4'd0,
    OP_SUB  = 4'd1,
    OP_AND  = 4'd2,
    OP_XOR  = 4'd3,
    OP_ADDI = 4'd4,
    OP_LW   = 4'd8,
    OP_SW   = 4'd9
  } opcodeE;

  // Register-register layout
  typedef struct packed {
    opcodeE                   op;
    logic [`CPU_REG_ID_W-1:0] rd;
    logic [`CPU_REG_ID_W-1:0] rs;
    logic [`CPU_REG_ID_W-1:0] rt;
  } rTypeS;

  // Immediate layout, also used by LW and SW (rd is the SW data register)
  typedef struct packed {
    opcodeE                   op;
    logic [`CPU_REG_ID_W-1:0] rd;
    logic [`CPU_REG_ID_W-1:0] rs;
    logic [3:0]               imm;  // Signed offset or constant
  } iTypeS;

  // One fetched word, seen either way by the decoder
  typedef union packed {
    rTypeS rType;
    iTypeS iType;
  } instrU;

  typedef enum logic [1:0] {FWD_NONE = 2'd0, FWD_WB = 2'd1, FWD_MEM = 2'd2} fwdSelE;

  typedef enum logic [1:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_XOR} aluOpE;

endpackage

//--- design/forwardUnit.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module forwardUnit (
  input  logic [`CPU_REG_ID_W-1:0] idExSrcReg1,    // First ALU source of the EX instruction
  input  logic [`CPU_REG_ID_W-1:0] idExSrcReg2,    // Second ALU source or SW data register
  input  logic [`CPU_REG_ID_W-1:0] exMemSrcReg2,   // SW data register now in MEM
  input  logic [`CPU_REG_ID_W-1:0] exMemRd,
  input  logic [`CPU_REG_ID_W-1:0] memWbRd,
  input  logic                     exMemRegWrite,  // EX/MEM holds a usable ALU result
  input  logic                     memWbRegWrite,
  output cpuPkg::fwdSelE           forwardA,
  output cpuPkg::fwdSelE           forwardB,
  output logic                     forwardMem      // Replace store data with the WB value
);
  logic exMemWrites;
  logic memWbWrites;

  // Register 0 is never a forwarding source
  assign exMemWrites = exMemRegWrite && (exMemRd != '0);
  assign memWbWrites = memWbRegWrite && (memWbRd != '0);

  // EX/MEM is checked first since it is the younger producer
  function automatic cpuPkg::fwdSelE pickSource(input logic [`CPU_REG_ID_W-1:0] src);
    if (exMemWrites && (exMemRd == src)) begin
      return cpuPkg::FWD_MEM;
    end else if (memWbWrites && (memWbRd == src)) begin
      return cpuPkg::FWD_WB;
    end
    return cpuPkg::FWD_NONE;
  endfunction

  ////////////////////
  // Per-operand selection
  always_comb begin
    forwardA = pickSource(idExSrcReg1);
    forwardB = pickSource(idExSrcReg2);  // Also steers the SW data captured in EX
  end

  // LW then SW of the loaded register meets here, with the load data one stage ahead
  assign forwardMem = memWbWrites && (memWbRd == exMemSrcReg2);

endmodule

//--- design/regFile.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module regFile (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic [`CPU_REG_ID_W-1:0] rdAddr1,
  input  logic [`CPU_REG_ID_W-1:0] rdAddr2,
  input  logic                     wrEn,     // Retiring write from WB
  input  logic [`CPU_REG_ID_W-1:0] wrAddr,
  input  logic [`CPU_DATA_W-1:0]   wrData,
  output logic [`CPU_DATA_W-1:0]   rdData1,
  output logic [`CPU_DATA_W-1:0]   rdData2
);
  logic [`CPU_DATA_W-1:0] regs [`CPU_NUM_REGS];

  // A write in the same cycle shows up at once, so ID never needs a WB bypass
  function automatic logic [`CPU_DATA_W-1:0] readPort(input logic [`CPU_REG_ID_W-1:0] addr);
    if (addr == '0) return '0;
    if (wrEn && (wrAddr == addr)) return wrData;
    return regs[addr];
  endfunction

  always_comb begin
    rdData1 = readPort(rdAddr1);
    rdData2 = readPort(rdAddr2);
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `CPU_NUM_REGS; i++) regs[i] <= '0;
    end else if (wrEn && (wrAddr != '0)) begin
      regs[wrAddr] <= wrData;
    end
  end

  // Decode already strips register 0 writes, long before they reach here
  assert property (@(posedge clk) disable iff (!rstN) wrEn |-> (wrAddr != '0));

endmodule

//--- design/execStage.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module execStage (
  input  logic                   clk,
  input  logic                   rstN,
  input  logic                   idExLoad,        // Capture new operands from ID
  input  logic [`CPU_DATA_W-1:0] rdData1,
  input  logic [`CPU_DATA_W-1:0] rdData2,
  input  logic [3:0]             immVal,
  input  cpuPkg::aluOpE          aluOp,
  input  logic                   useImm,          // ALU B takes the immediate
  input  cpuPkg::fwdSelE         forwardA,
  input  cpuPkg::fwdSelE         forwardB,
  input  logic [`CPU_DATA_W-1:0] memFwdData,      // EX/MEM result
  input  logic [`CPU_DATA_W-1:0] wbFwdData,       // MEM/WB value
  output logic [`CPU_DATA_W-1:0] exMemResult,
  output logic [`CPU_DATA_W-1:0] exMemStoreData
);
  logic [`CPU_DATA_W-1:0] opA;
  logic [`CPU_DATA_W-1:0] opB;
  logic [`CPU_DATA_W-1:0] immExt;
  logic [`CPU_DATA_W-1:0] aluA;
  logic [`CPU_DATA_W-1:0] fwdB;    // Forwarded rt, or SW data
  logic [`CPU_DATA_W-1:0] aluB;
  logic [`CPU_DATA_W-1:0] aluOut;

  function automatic logic [`CPU_DATA_W-1:0] fwdMux(input cpuPkg::fwdSelE sel,
      input logic [`CPU_DATA_W-1:0] regVal, input logic [`CPU_DATA_W-1:0] memVal,
      input logic [`CPU_DATA_W-1:0] wbVal);
    case (sel)
      cpuPkg::FWD_MEM: return memVal;
      cpuPkg::FWD_WB:  return wbVal;
      default:         return regVal;
    endcase
  endfunction

  ////////////////////
  // ID/EX operands
  always_ff @(posedge clk) begin
    if (!rstN) begin
      opA    <= '0;
      opB    <= '0;
      immExt <= '0;
    end else if (idExLoad) begin
      opA    <= rdData1;
      opB    <= rdData2;
      immExt <= {{(`CPU_DATA_W-4){immVal[3]}}, immVal};  // Offsets run from -8 to 7
    end
  end

  assign aluA = fwdMux(forwardA, opA, memFwdData, wbFwdData);
  assign fwdB = fwdMux(forwardB, opB, memFwdData, wbFwdData);
  assign aluB = useImm ? immExt : fwdB;

  always_comb begin
    aluOut = aluA + aluB;
    case (aluOp)
      cpuPkg::ALU_SUB: aluOut = aluA - aluB;
      cpuPkg::ALU_AND: aluOut = aluA & aluB;
      cpuPkg::ALU_XOR: aluOut = aluA ^ aluB;
      default:         aluOut = aluA + aluB;
    endcase
  end

  // EX/MEM result, doubling as the LW and SW address
  always_ff @(posedge clk) begin
    exMemResult    <= aluOut;
    exMemStoreData <= fwdB;
  end

endmodule

//--- design/memStage.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module memStage (
  input  logic                              clk,
  input  logic                              rstN,
  input  logic [`CPU_DATA_W-1:0]            exMemResult,     // ALU value or address
  input  logic [`CPU_DATA_W-1:0]            exMemStoreData,
  input  logic                              memRead,
  input  logic                              memWrite,
  input  logic                              forwardMem,      // Take store data from MEM/WB
  output logic [`CPU_DATA_W-1:0]            wbData,
  output logic                              storeValid,
  output logic [$clog2(`CPU_MEM_DEPTH)-1:0] storeAddr,
  output logic [`CPU_DATA_W-1:0]            storeData
);
  localparam int AddrW = $clog2(`CPU_MEM_DEPTH);

  logic [`CPU_DATA_W-1:0] dataMem [`CPU_MEM_DEPTH];
  logic [AddrW-1:0]       addr;
  logic [`CPU_DATA_W-1:0] stData;

  assign addr   = exMemResult[AddrW-1:0];  // High address bits are ignored
  assign stData = forwardMem ? wbData : exMemStoreData;

  ////////////////////
  // Data memory and store port
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < `CPU_MEM_DEPTH; i++) dataMem[i] <= '0;
      storeValid <= 1'b0;
    end else begin
      if (memWrite) dataMem[addr] <= stData;
      storeValid <= memWrite;  // Pulse lines up with the memory write
    end
  end

  // MEM/WB value feeds write-back, MEM-to-EX and MEM-to-MEM
  always_ff @(posedge clk) begin
    wbData    <= memRead ? dataMem[addr] : exMemResult;
    storeAddr <= addr;
    storeData <= stData;
  end

  // Decode never marks one instruction as both LW and SW
  assert property (@(posedge clk) disable iff (!rstN) !(memRead && memWrite));

endmodule

//--- design/pipeControl.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module pipeControl (
  input  logic                     clk,
  input  logic                     rstN,
  input  logic                     instrValid,
  input  cpuPkg::instrU            instr,
  output logic                     stall,      // Load-use hold, one cycle
  output logic [`CPU_REG_ID_W-1:0] rdAddr1,
  output logic [`CPU_REG_ID_W-1:0] rdAddr2,
  output logic [3:0]               immVal,     // Raw nibble, extended in EX
  output logic                     idExLoad,
  output cpuPkg::aluOpE            aluOp,
  output logic                     useImm,
  output cpuPkg::fwdSelE           forwardA,
  output cpuPkg::fwdSelE           forwardB,
  output logic                     memRead,
  output logic                     memWrite,
  output logic                     forwardMem,
  output logic                     wbValid,
  output logic [`CPU_REG_ID_W-1:0] wbReg
);
  cpuPkg::instrU             ifIdInstr;
  logic                      ifIdValid;
  logic                      isAlu;
  logic                      isAddi;
  logic                      isLw;
  logic                      isSw;
  logic                      decRegWr;
  logic [`CPU_REG_ID_W-1:0]  decSrc2;      // rt for ALU ops, rd for SW, else zero
  cpuPkg::aluOpE             decAluOp;
  logic                      idExValid, idExRegWr, idExMemRead, idExMemWrite;
  logic [`CPU_REG_ID_W-1:0]  idExRd, idExSrc1, idExSrc2;
  logic                      exMemValid, exMemRegWr, exMemMemRead, exMemMemWrite;
  logic [`CPU_REG_ID_W-1:0]  exMemRd, exMemSrc2;
  logic                      memWbValid, memWbRegWr;
  logic [`CPU_REG_ID_W-1:0]  memWbRd;
  logic                      exMemFwdWrite;

  ////////////////////
  // Decode through the instruction union
  always_comb begin
    isAlu    = 1'b0;
    isAddi   = 1'b0;
    isLw     = 1'b0;
    isSw     = 1'b0;
    decAluOp = cpuPkg::ALU_ADD;  // Address arithmetic for ADDI, LW and SW
    case (ifIdInstr.rType.op)
      cpuPkg::OP_ADD:  isAlu = 1'b1;
      cpuPkg::OP_SUB:  begin
        isAlu    = 1'b1;
        decAluOp = cpuPkg::ALU_SUB;
      end
      cpuPkg::OP_AND:  begin
        isAlu    = 1'b1;
        decAluOp = cpuPkg::ALU_AND;
      end
      cpuPkg::OP_XOR:  begin
        isAlu    = 1'b1;
        decAluOp = cpuPkg::ALU_XOR;
      end
      cpuPkg::OP_ADDI: isAddi = 1'b1;
      cpuPkg::OP_LW:   isLw = 1'b1;
      cpuPkg::OP_SW:   isSw = 1'b1;
      default:         isAlu = 1'b0;  // Unknown opcodes retire as bubbles
    endcase
  end

  // Writes to register 0 are dropped here so no later stage sees them
  assign decRegWr = ifIdValid && (isAlu || isAddi || isLw) && (ifIdInstr.rType.rd != '0);
  assign decSrc2  = isSw ? ifIdInstr.iType.rd : (isAlu ? ifIdInstr.rType.rt : '0);
  assign rdAddr1  = ifIdInstr.rType.rs;
  assign rdAddr2  = decSrc2;
  assign immVal   = ifIdInstr.iType.imm;

  // Load data is ready only after MEM, so an ALU or address use right behind a LW waits.
  // The SW data register is left out because MEM-to-MEM forwarding covers it
  assign stall = ifIdValid && idExValid && idExMemRead && idExRegWr &&
                 ((ifIdInstr.rType.rs == idExRd) || (isAlu && ifIdInstr.rType.rt == idExRd));
  assign idExLoad = ifIdValid && !stall;

  ////////////////////
  // Pipeline registers
  always_ff @(posedge clk) begin
    if (!stall) begin
      ifIdInstr <= instr;  // Held while stalled, fetch holds the same word
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      ifIdValid  <= 1'b0;
      idExValid  <= 1'b0;
      exMemValid <= 1'b0;
      memWbValid <= 1'b0;
    end else begin
      if (!stall) ifIdValid <= instrValid;
      idExValid  <= idExLoad;  // A stall drops a bubble into ID/EX
      exMemValid <= idExValid;
      memWbValid <= exMemValid;
    end
  end

  always_ff @(posedge clk) begin
    idExRegWr     <= decRegWr;
    idExMemRead   <= isLw;
    idExMemWrite  <= isSw;
    idExRd        <= ifIdInstr.rType.rd;
    idExSrc1      <= ifIdInstr.rType.rs;
    idExSrc2      <= decSrc2;
    aluOp         <= decAluOp;
    useImm        <= isAddi || isLw || isSw;
    exMemRegWr    <= idExRegWr;
    exMemMemRead  <= idExMemRead;
    exMemMemWrite <= idExMemWrite;
    exMemRd       <= idExRd;
    exMemSrc2     <= idExSrc2;
    memWbRegWr    <= exMemRegWr;
    memWbRd       <= exMemRd;
  end

  assign memRead  = exMemValid && exMemMemRead;
  assign memWrite = exMemValid && exMemMemWrite;
  assign wbValid  = memWbValid && memWbRegWr;
  assign wbReg    = memWbRd;
  // A LW in EX/MEM only holds its address, so it may not feed EX
  assign exMemFwdWrite = exMemValid && exMemRegWr && !exMemMemRead;

  forwardUnit u_forwardUnit (
    .idExSrcReg1   (idExSrc1),
    .idExSrcReg2   (idExSrc2),
    .exMemSrcReg2  (exMemSrc2),
    .exMemRd       (exMemRd),
    .memWbRd       (memWbRd),
    .exMemRegWrite (exMemFwdWrite),
    .memWbRegWrite (wbValid),
    .forwardA, .forwardB, .forwardMem
  );

  // The LW behind a stall moves on into MEM while its bubble ends the hold
  assert property (@(posedge clk) disable iff (!rstN)
    stall |=> (memRead && !stall));

  assert property (@(posedge clk) disable iff (!rstN) wbValid |-> (wbReg != '0));

endmodule

//--- design/cpuTop.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpuTop (
  input  logic                               clk,
  input  logic                               rstN,
  input  logic                               instrValid,  // Fetch offers instr this cycle
  input  cpuPkg::instrU                      instr,
  output logic                               stall,       // Fetch must hold instr
  output logic                               wbValid,     // One pulse per retiring write
  output logic [`CPU_REG_ID_W-1:0]           wbReg,
  output logic [`CPU_DATA_W-1:0]             wbData,
  output logic                               storeValid,  // One pulse per SW
  output logic [$clog2(`CPU_MEM_DEPTH)-1:0]  storeAddr,
  output logic [`CPU_DATA_W-1:0]             storeData
);

  ////////////////////
  // Control to datapath wiring
  logic [`CPU_REG_ID_W-1:0] rdAddr1;
  logic [`CPU_REG_ID_W-1:0] rdAddr2;
  logic [`CPU_DATA_W-1:0]   rdData1;
  logic [`CPU_DATA_W-1:0]   rdData2;
  logic [3:0]               immVal;
  logic                     idExLoad;
  cpuPkg::aluOpE            aluOp;
  logic                     useImm;
  cpuPkg::fwdSelE           forwardA;
  cpuPkg::fwdSelE           forwardB;
  logic                     memRead;
  logic                     memWrite;
  logic                     forwardMem;
  logic [`CPU_DATA_W-1:0]   exMemResult;     // ALU result or memory address
  logic [`CPU_DATA_W-1:0]   exMemStoreData;

  pipeControl u_pipeControl (
    .clk, .rstN, .instrValid, .instr, .stall,
    .rdAddr1, .rdAddr2, .immVal, .idExLoad, .aluOp, .useImm,
    .forwardA, .forwardB, .memRead, .memWrite, .forwardMem,
    .wbValid, .wbReg
  );

  // Write port is fed straight from the MEM/WB stage
  regFile u_regFile (
    .clk, .rstN, .rdAddr1, .rdAddr2,
    .wrEn   (wbValid),
    .wrAddr (wbReg),
    .wrData (wbData),
    .rdData1, .rdData2
  );

  execStage u_execStage (
    .clk, .rstN, .idExLoad, .rdData1, .rdData2, .immVal, .aluOp, .useImm,
    .forwardA, .forwardB,
    .memFwdData (exMemResult),  // EX-to-EX source
    .wbFwdData  (wbData),       // MEM-to-EX source
    .exMemResult, .exMemStoreData
  );

  memStage u_memStage (
    .clk, .rstN, .exMemResult, .exMemStoreData, .memRead, .memWrite, .forwardMem,
    .wbData, .storeValid, .storeAddr, .storeData
  );

endmodule

//--- verif/tbClock.sv
`timescale 1ns/1ps

// Free-running testbench clock, 4 ns period
module tbClock (
  output logic clk
);
  localparam realtime HalfPeriod = 2.0;  // Half of the 4 ns period

  ////////////////////
  // Clock toggle
  initial begin
    clk = 1'b0;  // First rising edge lands at 2 ns
  end

  always begin
    #(HalfPeriod);
    clk = ~clk;
  end

endmodule

//--- verif/cpuTb.sv
`timescale 1ns/1ps
`include "cpu_cfg.svh"

module cpuTb;
  localparam int AddrW        = $clog2(`CPU_MEM_DEPTH);
  localparam int ResetCycles  = 16;
  localparam int StallLimit   = 8;   // Cycles fetch may be held before giving up
  localparam int DrainLimit   = 64;  // Cycles allowed for the last records to retire
  localparam int SettleCycles = 8;   // Longer than the 4-cycle retire latency

  logic                     clk;
  logic                     rstN;
  logic                     instrValid;
  cpuPkg::instrU            instr;
  logic                     stall;
  logic                     wbValid;
  logic [`CPU_REG_ID_W-1:0] wbReg;
  logic [`CPU_DATA_W-1:0]   wbData;
  logic                     storeValid;
  logic [AddrW-1:0]         storeAddr;
  logic [`CPU_DATA_W-1:0]   storeData;

  // Program and expected records, filled from the stimulus file
  cpuPkg::instrU            progQ[$];
  bit                       chainQ[$];    // Next instruction follows with no gap
  logic [`CPU_REG_ID_W-1:0] wbRegQ[$];
  logic [`CPU_DATA_W-1:0]   wbDataQ[$];
  string                    wbNameQ[$];
  logic [AddrW-1:0]         stAddrQ[$];
  logic [`CPU_DATA_W-1:0]   stDataQ[$];
  string                    stNameQ[$];
  int                       expStalls;
  int                       stallCycles;
  logic                     stallPrev;
  int                       wbErrors;
  int                       storeErrors;
  int                       stallErrors;
  int                       otherErrors;
  bit                       runAborted;
  logic [31:0]              rngState;

  tbClock u_tbClock (.clk);

  cpuTop u_cpuTop (
    .clk, .rstN, .instrValid, .instr, .stall,
    .wbValid, .wbReg, .wbData, .storeValid, .storeAddr, .storeData
  );

  ////////////////////
  // Helpers
  function automatic logic [31:0] nextRandom();
    logic [31:0] x;
    x = rngState;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rngState = x;
    return x;
  endfunction

  // Test name is the last word on a record line
  function automatic string lastWord(input string s);
    int stop;
    int start;
    stop = s.len() - 1;
    while (stop >= 0 && (s.getc(stop) == "\n" || s.getc(stop) == "\r" || s.getc(stop) == " ")) begin
      stop--;
    end
    start = stop;
    while (start > 0 && s.getc(start - 1) != " ") start--;
    return s.substr(start, stop);
  endfunction

  task automatic loadStimulus();
    int          fd;
    int          code;
    int          chain;
    int          stalls;
    string       line;
    string       rest;
    byte         kind;
    logic [15:0] a;
    logic [15:0] b;
    fd = $fopen("verif/cpu_stimulus.txt", "r");
    if (fd == 0) begin
      $display("Could not open verif/cpu_stimulus.txt");
      otherErrors++;
      runAborted = 1'b1;
    end else begin
      while (!$feof(fd)) begin
        code = $fgets(line, fd);
        kind = (code > 0) ? line.getc(0) : 8'd0;
        rest = line.substr(2, line.len() - 1);
        case (kind)
          "I": begin
            code = $sscanf(rest, "%h %d %d", a, chain, stalls);
            progQ.push_back(a);
            chainQ.push_back(chain != 0);
            expStalls += stalls;  // Stall cycles caused by this instruction in ID
          end
          "W": begin
            code = $sscanf(rest, "%h %h", a, b);
            wbRegQ.push_back(a[`CPU_REG_ID_W-1:0]);
            wbDataQ.push_back(b);
            wbNameQ.push_back(lastWord(line));
          end
          "S": begin
            code = $sscanf(rest, "%h %h", a, b);
            stAddrQ.push_back(a[AddrW-1:0]);
            stDataQ.push_back(b);
            stNameQ.push_back(lastWord(line));
          end
          default: code = 0;  // Comment or blank line
        endcase
      end
      $fclose(fd);
    end
  endtask

  ////////////////////
  // Compare tasks
  task automatic checkWb(input string name, input logic [`CPU_REG_ID_W-1:0] expReg,
      input logic [`CPU_DATA_W-1:0] expData, input logic [`CPU_REG_ID_W-1:0] actReg,
      input logic [`CPU_DATA_W-1:0] actData);
    if (actReg !== expReg || actData !== expData) begin
      wbErrors++;
      $display("CHECK FAILED %s: write-back expected r%0d=%h, actual r%0d=%h",
               name, expReg, expData, actReg, actData);
    end
  endtask

  task automatic checkStore(input string name, input logic [AddrW-1:0] expAddr,
      input logic [`CPU_DATA_W-1:0] expData, input logic [AddrW-1:0] actAddr,
      input logic [`CPU_DATA_W-1:0] actData);
    if (actAddr !== expAddr || actData !== expData) begin
      storeErrors++;
      $display("CHECK FAILED %s: store expected [%h]=%h, actual [%h]=%h",
               name, expAddr, expData, actAddr, actData);
    end
  endtask

  task automatic checkStall(input string name, input int expCycles, input int actCycles);
    if (actCycles != expCycles) begin
      stallErrors++;
      $display("CHECK FAILED %s: stall cycles expected %0d, actual %0d",
               name, expCycles, actCycles);
    end
  endtask

  ////////////////////
  // Fetch driver
  // Called right after a rising edge, returns right after the edge that accepts the word
  task automatic sendInstr(input cpuPkg::instrU word);
    int   waits;
    logic accepted;
    waits    = 0;
    accepted = 1'b0;
    instrValid <= 1'b1;
    instr      <= word;
    while (!accepted && !runAborted) begin
      @(negedge clk);
      accepted = !stall;  // Stall is settled mid-cycle
      @(posedge clk);
      if (!accepted) begin
        waits++;
        if (waits > StallLimit) begin
          $display("Timeout: fetch held by stall for %0d cycles on %h", waits, word);
          otherErrors++;
          runAborted = 1'b1;
        end
      end
    end
  endtask

  task automatic drainRecords();
    int waits;
    waits = 0;
    while ((wbRegQ.size() > 0 || stAddrQ.size() > 0) && !runAborted) begin
      @(posedge clk);
      waits++;
      if (waits > DrainLimit) begin
        $display("Timeout: %0d write-back and %0d store records never retired",
                 wbRegQ.size(), stAddrQ.size());
        otherErrors++;
        runAborted = 1'b1;
      end
    end
  endtask

  ////////////////////
  // Monitors, sampled on the falling edge where outputs are stable
  always @(negedge clk) begin
    if (rstN && wbValid) begin
      if (wbRegQ.size() == 0) begin
        wbErrors++;
        $display("Unexpected write-back r%0d=%h with no record left", wbReg, wbData);
      end else begin
        checkWb(wbNameQ.pop_front(), wbRegQ.pop_front(), wbDataQ.pop_front(), wbReg, wbData);
      end
    end
  end

  always @(negedge clk) begin
    if (rstN && storeValid) begin
      if (stAddrQ.size() == 0) begin
        storeErrors++;
        $display("Unexpected store [%h]=%h with no record left", storeAddr, storeData);
      end else begin
        checkStore(stNameQ.pop_front(), stAddrQ.pop_front(), stDataQ.pop_front(),
                   storeAddr, storeData);
      end
    end
  end

  // A load-use bubble is a single cycle, two in a row is a fault
  always @(negedge clk) begin
    if (rstN) begin
      if (stall) begin
        stallCycles++;
        if (stallPrev) begin
          stallErrors++;
          $display("Stall stayed high for more than one cycle");
        end
      end
      stallPrev = stall;
    end else begin
      stallPrev = 1'b0;
    end
  end

  ////////////////////
  // Main sequence
  initial begin
    int gap;
    rstN        = 1'b0;
    instrValid  = 1'b0;
    instr       = '0;
    rngState    = 32'hc7a4df80;
    expStalls   = 0;
    stallCycles = 0;
    wbErrors    = 0;
    storeErrors = 0;
    stallErrors = 0;
    otherErrors = 0;
    runAborted  = 1'b0;
    loadStimulus();
    repeat (ResetCycles) @(posedge clk);
    rstN <= 1'b1;
    @(negedge clk);
    if (stall || wbValid || storeValid) begin
      otherErrors++;
      $display("CHECK FAILED reset: expected stall/wbValid/storeValid 000, actual %b%b%b",
               stall, wbValid, storeValid);
    end
    @(posedge clk);
    for (int i = 0; i < progQ.size() && !runAborted; i++) begin
      sendInstr(progQ[i]);
      if (!chainQ[i]) begin
        gap = int'(nextRandom() % 32'd3);  // 0 to 2 idle cycles between groups
        if (gap > 0) begin
          instrValid <= 1'b0;
          repeat (gap) @(posedge clk);
        end
      end
    end
    instrValid <= 1'b0;
    drainRecords();
    for (int i = 0; i < SettleCycles; i++) @(posedge clk);  // Catch stray pulses
    checkStall("loaduse", expStalls, stallCycles);
    $display("Errors: write-back %0d, store %0d, stall %0d, other %0d",
             wbErrors, storeErrors, stallErrors, otherErrors);
    if (!runAborted && (wbErrors + storeErrors + stallErrors + otherErrors) == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- verif/cpu_stimulus.txt
# I <instr hex> <chain: 1 = next follows with no gap> <stall cycles it causes in ID>
# W <reg hex> <data hex> <test>   S <addr hex> <data hex> <test>
I 4105 0 0
W 1 0005 indep
I 420D 0 0
W 2 FFFD indep
I 4307 0 0
W 3 0007 indep
I 0413 0 0
W 4 000C indep
I 1512 0 0
W 5 0008 indep
I 2623 0 0
W 6 0005 indep
I 3721 0 0
W 7 FFF8 indep
I 0011 0 0
I 4011 0 0
I 4801 1 0
W 8 0001 exfwd
I 0888 1 0
W 8 0002 exfwd
I 0888 1 0
W 8 0004 exfwd
I 1981 0 0
W 9 FFFF exfwd
I 4A06 1 0
W A 0006 wbfwd
I 4B02 1 0
W B 0002 wbfwd
I 3C3A 0 0
W C 0001 wbfwd
I 4D03 1 0
W D 0003 younger
I 4DD4 1 0
W D 0007 younger
I 0EDD 0 0
W E 000E younger
I 9433 0 0
S 0A 000C loaduse
I 8533 1 0
W 5 000C loaduse
I 0F51 0 1
W F 0011 loaduse
I 974F 0 0
S 0B FFF8 loaduse
I 894F 1 0
W 9 FFF8 loaduse
I 3A19 0 1
W A FFFD loaduse
I 8B34 1 0
W B FFF8 memfwd
I 9B36 0 0
S 0D FFF8 memfwd
I 8C36 0 0
W C FFF8 memfwd

//--- filelist.f
+incdir+common
common/cpuPkg.sv
design/forwardUnit.sv
design/regFile.sv
design/execStage.sv
design/memStage.sv
design/pipeControl.sv
design/cpuTop.sv
verif/tbClock.sv
verif/cpuTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cpuTb -f filelist.f -o cpuSim

out=$(./obj_dir/cpuSim) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx '>>> PASS'; then
  exit 0
fi
exit 1
